//--- verilog/meas_pkg.sv
package meas_pkg;

    // Edge count per gate window.
    localparam int CODE_W = 28;

    // Window number, wraps freely.
    localparam int SEQ_W = 4;

    // One finished window as it travels through the FIFO.
    typedef struct packed {
        logic [SEQ_W-1:0]  seq;
        logic [CODE_W-1:0] code;
    } meas_t;

endpackage

//--- verilog/io_pkg.sv
package io_pkg;

    localparam int ADDR_W = 2;
    localparam int DATA_W = 16;

    typedef logic [DATA_W-1:0] io_data_t;

    // Host request, held stable while req is high.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              wr;
        io_data_t          wdata;
    } io_req_t;

    // Register map.
    localparam logic [ADDR_W-1:0] ADDR_STATUS  = 2'd0;
    localparam logic [ADDR_W-1:0] ADDR_CODE_LO = 2'd1;
    // Reading the high half pops the head record.
    localparam logic [ADDR_W-1:0] ADDR_CODE_HI = 2'd2;
    localparam logic [ADDR_W-1:0] ADDR_CTRL    = 2'd3;

endpackage

//--- verilog/freq_counter.sv
module freq_counter
    import meas_pkg::*;
#(
    parameter int GATE_CYCLES = 1000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  iclk,
    input  logic  enable,
    output logic  push,
    output meas_t rec
);

    localparam int WIN_W = (GATE_CYCLES > 1) ? $clog2(GATE_CYCLES) : 1;
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(GATE_CYCLES - 1);

    logic [2:0]        iclk_sync;
    logic              rise;
    logic [WIN_W-1:0]  win_cnt;
    logic              win_last;
    logic [CODE_W-1:0] edge_cnt;
    logic [SEQ_W-1:0]  seq;

    // Two synchronizer stages, the third flop feeds the edge detector.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iclk_sync <= '0;
        end else begin
            iclk_sync <= {iclk_sync[1:0], iclk};
        end
    end

    assign rise = iclk_sync[1] & ~iclk_sync[2];

    assign win_last = (win_cnt == WIN_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt <= '0;
        end else if (!enable || win_last) begin
            win_cnt <= '0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    // An edge in the last cycle opens the next window's count.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_cnt <= '0;
        end else if (!enable) begin
            edge_cnt <= '0;
        end else if (win_last) begin
            edge_cnt <= CODE_W'(rise);
        end else if (rise) begin
            edge_cnt <= edge_cnt + 1'b1;
        end
    end

    // Every window gets a number, even one the FIFO drops.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq <= '0;
        end else if (push) begin
            seq <= seq + 1'b1;
        end
    end

    assign push     = enable & win_last;
    assign rec.seq  = seq;
    assign rec.code = edge_cnt;

endmodule

//--- verilog/meas_fifo.sv
module meas_fifo
    import meas_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push,
    input  meas_t                         rec,
    input  logic                          pop,
    output meas_t                         head,
    output logic                          empty,
    output logic                          full,
    output logic [$clog2(FIFO_DEPTH):0]   count,
    output logic                          drop
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    meas_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign drop    = push & full;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= rec;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone.
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head = mem[rd_ptr];

endmodule

//--- verilog/io_bridge.sv
module io_bridge
    import meas_pkg::*;
    import io_pkg::*;
#(
    parameter int COUNT_W = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  io_req_t            io_req,
    input  meas_t              head,
    input  logic               empty,
    input  logic [COUNT_W-1:0] count,
    input  logic               drop,
    output logic               ack,
    output io_data_t           rdata,
    output logic               pop,
    output logic               enable,
    output logic               irq
);

    logic     access;
    logic     rd_access;
    logic     wr_access;
    logic     irq_en;
    logic     dropped;
    io_data_t status_word;
    io_data_t code_lo_word;
    io_data_t code_hi_word;
    io_data_t ctrl_word;

    // Exactly one access per transfer, in the first cycle of req.
    assign access    = req & ~ack;
    assign rd_access = access & ~io_req.wr;
    assign wr_access = access & io_req.wr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (access) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    assign status_word  = {8'b0, 4'(count), 2'b0, dropped, ~empty};
    assign code_lo_word = empty ? '0 : head.code[15:0];
    assign code_hi_word = empty ? '0 : {head.seq, head.code[CODE_W-1:16]};
    assign ctrl_word    = {14'b0, irq_en, enable};

    always_ff @(posedge clk) begin
        if (rd_access) begin
            case (io_req.addr)
                ADDR_STATUS:  rdata <= status_word;
                ADDR_CODE_LO: rdata <= code_lo_word;
                ADDR_CODE_HI: rdata <= code_hi_word;
                default:      rdata <= ctrl_word;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop <= 1'b0;
        end else begin
            pop <= rd_access & (io_req.addr == ADDR_CODE_HI) & ~empty;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
            irq_en <= 1'b0;
        end else if (wr_access && io_req.addr == ADDR_CTRL) begin
            enable <= io_req.wdata[0];
            irq_en <= io_req.wdata[1];
        end
    end

    // A fresh drop wins over a clearing write in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dropped <= 1'b0;
        end else if (drop) begin
            dropped <= 1'b1;
        end else if (wr_access && io_req.addr == ADDR_STATUS) begin
            dropped <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= irq_en & ~empty;
        end
    end

endmodule

//--- verilog/freq_meter.sv
module freq_meter
    import meas_pkg::*;
    import io_pkg::*;
#(
    parameter int GATE_CYCLES = 1000,
    parameter int FIFO_DEPTH  = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     iclk,
    input  logic     req,
    input  io_req_t  io_req,
    output logic     ack,
    output io_data_t rdata,
    output logic     irq
);

    localparam int COUNT_W = $clog2(FIFO_DEPTH) + 1;

    logic               push;
    meas_t              rec;
    logic               pop;
    meas_t              head;
    logic               empty;
    logic [COUNT_W-1:0] count;
    logic               drop;
    logic               enable;

    // Producer.
    freq_counter #(
        .GATE_CYCLES (GATE_CYCLES)
    ) freq_counter_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .iclk   (iclk),
        .enable (enable),
        .push   (push),
        .rec    (rec)
    );

    // Full windows are dropped here and only reported through drop.
    meas_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) meas_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push),
        .rec   (rec),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (),
        .count (count),
        .drop  (drop)
    );

    io_bridge #(
        .COUNT_W (COUNT_W)
    ) io_bridge_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .io_req (io_req),
        .head   (head),
        .empty  (empty),
        .count  (count),
        .drop   (drop),
        .ack    (ack),
        .rdata  (rdata),
        .pop    (pop),
        .enable (enable),
        .irq    (irq)
    );

endmodule

//--- dv/freq_meter_tb.sv
module freq_meter_tb
    import meas_pkg::*;
    import io_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int GATE_CYCLES = 200;
    localparam int FIFO_DEPTH  = 8;
    // About 60 windows plus bus traffic.
    localparam int TIMEOUT_CYCLES = 60 * GATE_CYCLES + 8000;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     iclk = 1'b0;
    logic     req;
    io_req_t  io_req;
    logic     ack;
    io_data_t rdata;
    logic     irq;

    int cycle_cnt    = 0;
    int half_period  = 4;
    int iclk_cnt     = 0;
    int access_cycle = 0;

    freq_meter #(
        .GATE_CYCLES (GATE_CYCLES),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) freq_meter_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .iclk   (iclk),
        .req    (req),
        .io_req (io_req),
        .ack    (ack),
        .rdata  (rdata),
        .irq    (irq)
    );

    always #2 clk = ~clk;

    // Measured clock that toggles every half_period falling edges.
    always @(negedge clk) begin
        if (iclk_cnt >= half_period - 1) begin
            iclk_cnt <= 0;
            iclk     <= ~iclk;
        end else begin
            iclk_cnt <= iclk_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles.", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input io_data_t exp, input io_data_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_seq(input logic [SEQ_W-1:0] exp, input logic [SEQ_W-1:0] act);
        if (act !== exp) begin
            $display("Fail at %0t: seq expected %0d, got %0d", $time, exp, act);
            abort_run();
        end
    endtask

    task automatic check_code(input logic [CODE_W-1:0] lo_exp, input logic [CODE_W-1:0] hi_exp,
                              input logic [CODE_W-1:0] act);
        if ($isunknown(act) || !(act >= lo_exp && act <= hi_exp)) begin
            $display("Fail at %0t: code expected %0d..%0d, got %0d", $time, lo_exp, hi_exp, act);
            abort_run();
        end
    endtask

    // Edges of a 2*h cycle clock seen in one gate window.
    function automatic int expected_code(input int h, input bit round_up);
        int period;
        int edges;
        period = 2 * h;
        edges  = GATE_CYCLES / period;
        if (round_up && (GATE_CYCLES % period) != 0) begin
            edges = edges + 1;
        end
        return edges;
    endfunction

    // One four-phase transfer driven on falling edges.
    task automatic io_access(input logic [ADDR_W-1:0] addr, input logic wr,
                             input io_data_t wdata, output io_data_t data);
        @(negedge clk);
        req          = 1'b1;
        io_req.addr  = addr;
        io_req.wr    = wr;
        io_req.wdata = wdata;
        access_cycle = cycle_cnt;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        data = rdata;
        req  = 1'b0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end
    endtask

    task automatic io_write(input logic [ADDR_W-1:0] addr, input io_data_t wdata);
        io_data_t unused;
        io_access(addr, 1'b1, wdata, unused);
    endtask

    task automatic io_read(input logic [ADDR_W-1:0] addr, output io_data_t data);
        io_access(addr, 1'b0, '0, data);
    endtask

    task automatic read_record(output meas_t r);
        io_data_t lo;
        io_data_t hi;
        io_read(ADDR_CODE_LO, lo);
        io_read(ADDR_CODE_HI, hi);
        r.code = {hi[11:0], lo};
        r.seq  = hi[15:12];
    endtask

    task automatic wait_record();
        io_data_t st;
        do begin
            io_read(ADDR_STATUS, st);
        end while (!st[0]);
    endtask

    task automatic drain_fifo();
        io_data_t st;
        meas_t    r;
        io_read(ADDR_STATUS, st);
        while (st[0]) begin
            read_record(r);
            io_read(ADDR_STATUS, st);
        end
    endtask

    // Handshake timing and rdata hold on every transfer.
    initial begin : handshake_monitor
        logic     req_s;
        logic     ack_exp;
        logic     ack_prev;
        io_data_t rdata_hold;
        ack_exp    = 1'b0;
        ack_prev   = 1'b0;
        rdata_hold = '0;
        forever begin
            @(posedge clk);
            req_s = req;
            @(negedge clk);
            if (req_s && !ack_exp) begin
                ack_exp = 1'b1;
            end else if (!req_s) begin
                ack_exp = 1'b0;
            end
            check_bit("ack", ack_exp, ack);
            if (ack && !ack_prev) begin
                rdata_hold = rdata;
            end else if (ack_prev) begin
                check_word("rdata", rdata_hold, rdata);
            end
            ack_prev = ack;
        end
    end

    initial begin
        io_data_t         st;
        io_data_t         word;
        meas_t            rec;
        logic [SEQ_W-1:0] prev_seq;
        logic [SEQ_W-1:0] first_seq;
        int               t_en;
        int               windows;
        int unsigned      rnd;

        rnd    = $urandom(32'hb5fe);
        rst_n  = 1'b0;
        req    = 1'b0;
        io_req = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        check_bit("ack", 1'b0, ack);
        check_bit("irq", 1'b0, irq);
        io_read(ADDR_STATUS, st);
        check_word("status", 16'h0000, st);
        io_read(ADDR_CTRL, word);
        check_word("ctrl", 16'h0000, word);
        io_read(ADDR_CODE_LO, word);
        check_word("code_lo", 16'h0000, word);
        io_read(ADDR_CODE_HI, word);
        check_word("code_hi", 16'h0000, word);
        io_read(ADDR_STATUS, st);
        check_word("status", 16'h0000, st);

        // The first window after enable may span the change of iclk period.
        for (int p = 0; p < 4; p++) begin
            io_write(ADDR_CTRL, 16'h0000);
            drain_fifo();
            half_period = 2 + int'(rnd % 32'd8);
            rnd         = $urandom;
            io_write(ADDR_CTRL, 16'h0001);
            wait_record();
            read_record(rec);
            prev_seq = rec.seq;
            repeat (3) begin
                wait_record();
                read_record(rec);
                check_code(CODE_W'(expected_code(half_period, 1'b0)),
                           CODE_W'(expected_code(half_period, 1'b1)), rec.code);
                check_seq(prev_seq + SEQ_W'(1), rec.seq);
                prev_seq = rec.seq;
            end
        end

        io_write(ADDR_CTRL, 16'h0000);
        drain_fifo();
        io_write(ADDR_CTRL, 16'h0001);
        t_en = access_cycle;
        repeat (11 * GATE_CYCLES + 20) @(negedge clk);
        io_write(ADDR_CTRL, 16'h0000);
        windows = (access_cycle - t_en) / GATE_CYCLES;
        io_read(ADDR_STATUS, st);
        check_word("status", 16'h0083, st);
        read_record(rec);
        first_seq = rec.seq;
        prev_seq  = rec.seq;
        repeat (FIFO_DEPTH - 1) begin
            read_record(rec);
            check_seq(prev_seq + SEQ_W'(1), rec.seq);
            prev_seq = rec.seq;
        end
        io_read(ADDR_STATUS, st);
        check_word("status", 16'h0002, st);
        io_write(ADDR_STATUS, 16'h0000);
        io_read(ADDR_STATUS, st);
        check_word("status", 16'h0000, st);
        io_write(ADDR_CTRL, 16'h0001);
        wait_record();
        read_record(rec);
        check_seq(first_seq + SEQ_W'(windows), rec.seq);

        wait_record();
        check_bit("irq", 1'b0, irq);
        io_write(ADDR_CTRL, 16'h0002);
        check_bit("irq", 1'b1, irq);
        io_read(ADDR_CTRL, word);
        check_word("ctrl", 16'h0002, word);
        io_read(ADDR_STATUS, st);
        repeat (st[7:4]) begin
            check_bit("irq", 1'b1, irq);
            read_record(rec);
        end
        // Empty settles one cycle after the pop and irq one cycle later.
        @(negedge clk);
        check_bit("irq", 1'b0, irq);
        io_read(ADDR_STATUS, st);
        check_word("status", 16'h0000, st);
        io_write(ADDR_CTRL, 16'h0000);

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- freq_meter.f
verilog/meas_pkg.sv
verilog/io_pkg.sv
verilog/freq_counter.sv
verilog/meas_fifo.sv
verilog/io_bridge.sv
verilog/freq_meter.sv
dv/freq_meter_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module freq_meter_tb -f freq_meter.f -Mdir obj_dir &&
    ./obj_dir/Vfreq_meter_tb | tee sim.log

grep -qxs "TB PASSED" sim.log &&
    echo "Result: simulation passed" ||
    { echo "Result: simulation did not pass, see sim.log"; exit 1; }
